// File: logic/tlb_pkg.sv
package tlb_pkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------
  localparam int num_sets    = 64;
  localparam int set_idx_w   = 6;
  localparam int num_ways    = 2;

  // Sv39 address fields
  localparam int asid_w      = 16;
  localparam int vpn_w       = 27;
  localparam int vpn_field_w = 9;
  localparam int va_w        = 64;
  localparam int page_off_w  = 12;
  localparam int ppn_w       = 44;

  // Replacement counter width
  localparam int lru_w       = 3;

  // Permission and status bits of a page
  typedef struct packed {
    logic r;
    logic w;
    logic x;
    logic u;
    logic g;
    logic a;
    logic d;
  } tlb_perm_t;

  // --------------------------------------------------
  // Set index hash
  // --------------------------------------------------
  // Each VPN level field folds onto the index bits, bit j lands on j mod set_idx_w
  function automatic logic [set_idx_w-1:0] set_hash(
    input logic [asid_w-1:0] asid,
    input logic [vpn_w-1:0]  vpn
  );
    logic [set_idx_w-1:0] idx;
    idx = asid[set_idx_w-1:0];
    for (int f = 0; f < vpn_w / vpn_field_w; f++) begin
      for (int j = 0; j < vpn_field_w; j++) begin
        idx[j % set_idx_w] = idx[j % set_idx_w] ^ vpn[f * vpn_field_w + j];
      end
    end
    return idx;
  endfunction

endpackage

// File: logic/tlb_index_stage.sv
`timescale 1ns/10ps

module tlb_index_stage import tlb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 req_valid,
  input  logic [va_w-1:0]      req_vaddr,
  input  logic [asid_w-1:0]    req_asid,

  output logic                 lk_valid,
  output logic [set_idx_w-1:0] lk_set,
  output logic [asid_w-1:0]    lk_asid,
  output logic [vpn_w-1:0]     lk_vpn
);

  logic [vpn_w-1:0]     req_vpn;
  logic [set_idx_w-1:0] req_set;

  // VPN sits right above the page offset, bits 38..12 for Sv39
  assign req_vpn = req_vaddr[page_off_w +: vpn_w];
  assign req_set = set_hash(req_asid, req_vpn);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lk_valid <= 1'b0;
    end else begin
      lk_valid <= req_valid;
    end
  end

  // Lookup payload
  always_ff @(posedge clk) begin
    if (req_valid) begin
      lk_set  <= req_set;
      lk_asid <= req_asid;
      lk_vpn  <= req_vpn;
    end
  end

endmodule

// File: logic/tlb_way_array.sv
`timescale 1ns/10ps

module tlb_way_array import tlb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,

  // Lookup from the index stage
  input  logic                 lk_valid,
  input  logic [set_idx_w-1:0] lk_set,
  input  logic [asid_w-1:0]    lk_asid,
  input  logic [vpn_w-1:0]     lk_vpn,

  // Refill
  input  logic                 refill_valid,
  input  logic [asid_w-1:0]    refill_asid,
  input  logic [vpn_w-1:0]     refill_vpn,
  input  logic [ppn_w-1:0]     refill_ppn,
  input  tlb_perm_t            refill_perm,
  input  logic                 victim_way,

  // Maintenance
  input  logic                 inv_all,
  input  logic                 inv_asid_valid,
  input  logic [asid_w-1:0]    inv_asid,

  // Compare results
  output logic                 cmp_valid,
  output logic [set_idx_w-1:0] cmp_set,
  output logic [num_ways-1:0]  way_hit,
  output logic [ppn_w-1:0]     way_ppn [num_ways],
  output tlb_perm_t            way_perm [num_ways],

  // Replacement side
  output logic [set_idx_w-1:0] refill_set,
  output logic                 fill_valid,
  output logic [set_idx_w-1:0] fill_set,
  output logic                 fill_way
);

  // --------------------------------------------------
  // Entry storage
  // --------------------------------------------------
  logic [num_sets-1:0] valid_q [num_ways];
  logic [asid_w-1:0]   asid_q  [num_ways][num_sets];
  logic [vpn_w-1:0]    vpn_q   [num_ways][num_sets];
  logic [ppn_w-1:0]    ppn_q   [num_ways][num_sets];
  tlb_perm_t           perm_q  [num_ways][num_sets];

  // --------------------------------------------------
  // Tag compare
  // --------------------------------------------------
  assign cmp_valid = lk_valid;
  assign cmp_set   = lk_set;

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      // Global entries ignore the ASID
      way_hit[w]  = valid_q[w][lk_set] &&
                    (vpn_q[w][lk_set] == lk_vpn) &&
                    (perm_q[w][lk_set].g || (asid_q[w][lk_set] == lk_asid));
      way_ppn[w]  = ppn_q[w][lk_set];
      way_perm[w] = perm_q[w][lk_set];
    end
  end

  // --------------------------------------------------
  // Refill way choice
  // --------------------------------------------------
  assign refill_set = set_hash(refill_asid, refill_vpn);

  always_comb begin
    if (!valid_q[0][refill_set]) begin
      fill_way = 1'b0;
    end else if (!valid_q[1][refill_set]) begin
      fill_way = 1'b1;
    end else begin
      fill_way = victim_way;
    end
  end

  assign fill_valid = refill_valid;
  assign fill_set   = refill_set;

  // --------------------------------------------------
  // Valid bits
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < num_ways; w++) begin
        valid_q[w] <= '0;
      end
    end else begin
      if (inv_all) begin
        for (int w = 0; w < num_ways; w++) begin
          valid_q[w] <= '0;
        end
      end else if (inv_asid_valid) begin
        for (int w = 0; w < num_ways; w++) begin
          for (int s = 0; s < num_sets; s++) begin
            if (!perm_q[w][s].g && (asid_q[w][s] == inv_asid)) begin
              valid_q[w][s] <= 1'b0;
            end
          end
        end
      end
      // Refill lands after any flush of the same edge
      if (refill_valid) begin
        valid_q[fill_way][refill_set] <= 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (refill_valid) begin
      asid_q[fill_way][refill_set] <= refill_asid;
      vpn_q[fill_way][refill_set]  <= refill_vpn;
      ppn_q[fill_way][refill_set]  <= refill_ppn;
      perm_q[fill_way][refill_set] <= refill_perm;
    end
  end

endmodule

// File: logic/tlb_replace.sv
`timescale 1ns/10ps

module tlb_replace import tlb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic [set_idx_w-1:0] refill_set,
  output logic                 victim_way,

  input  logic                 fill_valid,
  input  logic [set_idx_w-1:0] fill_set,
  input  logic                 fill_way,

  input  logic                 hit_valid,
  input  logic [set_idx_w-1:0] hit_set,
  input  logic                 hit_way
);

  logic [lru_w-1:0] cnt_q [num_ways][num_sets];

  function automatic logic [lru_w-1:0] sat_inc(input logic [lru_w-1:0] c);
    return (c == '1) ? c : c + 1'b1;
  endfunction

  function automatic logic [lru_w-1:0] sat_dec(input logic [lru_w-1:0] c);
    return (c == '0) ? c : c - 1'b1;
  endfunction

  // Lower counter is evicted, way 0 on a tie
  assign victim_way = (cnt_q[1][refill_set] < cnt_q[0][refill_set]);

  // --------------------------------------------------
  // Counter update
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < num_ways; w++) begin
        for (int s = 0; s < num_sets; s++) begin
          cnt_q[w][s] <= '0;
        end
      end
    end else begin
      if (hit_valid) begin
        cnt_q[hit_way][hit_set]  <= sat_inc(cnt_q[hit_way][hit_set]);
        cnt_q[!hit_way][hit_set] <= sat_dec(cnt_q[!hit_way][hit_set]);
      end
      // Written last so a fill overrides a hit on the same set
      if (fill_valid) begin
        cnt_q[fill_way][fill_set]  <= sat_inc(cnt_q[fill_way][fill_set]);
        cnt_q[!fill_way][fill_set] <= sat_dec(cnt_q[!fill_way][fill_set]);
      end
    end
  end

endmodule

// File: logic/tlb_resp_stage.sv
`timescale 1ns/10ps

module tlb_resp_stage import tlb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 cmp_valid,
  input  logic [set_idx_w-1:0] cmp_set,
  input  logic [num_ways-1:0]  way_hit,
  input  logic [ppn_w-1:0]     way_ppn [num_ways],
  input  tlb_perm_t            way_perm [num_ways],

  // Hit report to the replacement counters
  output logic                 hit_valid,
  output logic [set_idx_w-1:0] hit_set,
  output logic                 hit_way,

  output logic                 resp_valid,
  output logic                 resp_hit,
  output logic [ppn_w-1:0]     resp_ppn,
  output tlb_perm_t            resp_perm
);

  logic any_hit;

  assign any_hit = |way_hit;

  // Way 0 wins when both ways match
  assign hit_way   = !way_hit[0];
  assign hit_valid = cmp_valid && any_hit;
  assign hit_set   = cmp_set;

  // --------------------------------------------------
  // Response registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
      resp_hit   <= 1'b0;
    end else begin
      resp_valid <= cmp_valid;
      resp_hit   <= cmp_valid && any_hit;
    end
  end

  // Miss returns zero PPN and perms
  always_ff @(posedge clk) begin
    if (cmp_valid) begin
      if (any_hit) begin
        resp_ppn  <= way_ppn[hit_way];
        resp_perm <= way_perm[hit_way];
      end else begin
        resp_ppn  <= '0;
        resp_perm <= '0;
      end
    end
  end

endmodule

// File: logic/tlb_top.sv
`timescale 1ns/10ps

module tlb_top import tlb_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,

  // Lookup request
  input  logic              req_valid,
  input  logic [va_w-1:0]   req_vaddr,
  input  logic [asid_w-1:0] req_asid,

  // Refill from the page walker
  input  logic              refill_valid,
  input  logic [asid_w-1:0] refill_asid,
  input  logic [vpn_w-1:0]  refill_vpn,
  input  logic [ppn_w-1:0]  refill_ppn,
  input  tlb_perm_t         refill_perm,

  // Maintenance
  input  logic              inv_all,
  input  logic              inv_asid_valid,
  input  logic [asid_w-1:0] inv_asid,

  // Response
  output logic              resp_valid,
  output logic              resp_hit,
  output logic [ppn_w-1:0]  resp_ppn,
  output tlb_perm_t         resp_perm
);

  // --------------------------------------------------
  // Stage wiring
  // --------------------------------------------------
  logic                 lk_valid;
  logic [set_idx_w-1:0] lk_set;
  logic [asid_w-1:0]    lk_asid;
  logic [vpn_w-1:0]     lk_vpn;

  logic                 cmp_valid;
  logic [set_idx_w-1:0] cmp_set;
  logic [num_ways-1:0]  way_hit;
  logic [ppn_w-1:0]     way_ppn [num_ways];
  tlb_perm_t            way_perm [num_ways];

  logic [set_idx_w-1:0] refill_set;
  logic                 victim_way;
  logic                 fill_valid;
  logic [set_idx_w-1:0] fill_set;
  logic                 fill_way;

  logic                 hit_valid;
  logic [set_idx_w-1:0] hit_set;
  logic                 hit_way;

  tlb_index_stage u_index (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_vaddr (req_vaddr),
    .req_asid  (req_asid),
    .lk_valid  (lk_valid),
    .lk_set    (lk_set),
    .lk_asid   (lk_asid),
    .lk_vpn    (lk_vpn)
  );

  tlb_way_array u_ways (
    .clk            (clk),
    .rst_n          (rst_n),
    .lk_valid       (lk_valid),
    .lk_set         (lk_set),
    .lk_asid        (lk_asid),
    .lk_vpn         (lk_vpn),
    .refill_valid   (refill_valid),
    .refill_asid    (refill_asid),
    .refill_vpn     (refill_vpn),
    .refill_ppn     (refill_ppn),
    .refill_perm    (refill_perm),
    .victim_way     (victim_way),
    .inv_all        (inv_all),
    .inv_asid_valid (inv_asid_valid),
    .inv_asid       (inv_asid),
    .cmp_valid      (cmp_valid),
    .cmp_set        (cmp_set),
    .way_hit        (way_hit),
    .way_ppn        (way_ppn),
    .way_perm       (way_perm),
    .refill_set     (refill_set),
    .fill_valid     (fill_valid),
    .fill_set       (fill_set),
    .fill_way       (fill_way)
  );

  tlb_replace u_replace (
    .clk        (clk),
    .rst_n      (rst_n),
    .refill_set (refill_set),
    .victim_way (victim_way),
    .fill_valid (fill_valid),
    .fill_set   (fill_set),
    .fill_way   (fill_way),
    .hit_valid  (hit_valid),
    .hit_set    (hit_set),
    .hit_way    (hit_way)
  );

  tlb_resp_stage u_resp (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmp_valid  (cmp_valid),
    .cmp_set    (cmp_set),
    .way_hit    (way_hit),
    .way_ppn    (way_ppn),
    .way_perm   (way_perm),
    .hit_valid  (hit_valid),
    .hit_set    (hit_set),
    .hit_way    (hit_way),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_ppn   (resp_ppn),
    .resp_perm  (resp_perm)
  );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst_n
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Release just after an edge so the first sampled edge sees a clean reset
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/10ps

module tb_top import tlb_pkg::*; ();

  localparam int reset_cycles    = 16;
  localparam int directed_cycles = 80;
  localparam int random_cycles   = 400;
  localparam int timeout_cycles  = 2 * (reset_cycles + directed_cycles + random_cycles) + 100;
  localparam int cnt_max         = 2 ** lru_w - 1;

  typedef struct packed {
    logic             hit;
    logic             way;
    logic [ppn_w-1:0] ppn;
    tlb_perm_t        perm;
  } exp_t;

  logic              clk, rst_n;
  logic              req_valid, refill_valid, inv_all, inv_asid_valid;
  logic              resp_valid, resp_hit;
  logic [va_w-1:0]   req_vaddr;
  logic [asid_w-1:0] req_asid, refill_asid, inv_asid;
  logic [vpn_w-1:0]  refill_vpn;
  logic [ppn_w-1:0]  refill_ppn, resp_ppn;
  tlb_perm_t         refill_perm, resp_perm;

  // --------------------------------------------------
  // Reference model state
  // --------------------------------------------------
  logic              m_valid [num_ways][num_sets];
  logic [asid_w-1:0] m_asid  [num_ways][num_sets];
  logic [vpn_w-1:0]  m_vpn   [num_ways][num_sets];
  logic [ppn_w-1:0]  m_ppn   [num_ways][num_sets];
  tlb_perm_t         m_perm  [num_ways][num_sets];
  int                m_cnt   [num_ways][num_sets];

  // Lookup sitting in the index stage
  logic              pend_valid;
  logic [asid_w-1:0] pend_asid;
  logic [vpn_w-1:0]  pend_vpn;

  exp_t exp_q [$];
  int   exp_cyc_q [$];
  int   cyc = 0;
  int   seed;

  tb_clock #(.reset_cycles(reset_cycles)) u_clk (.clk(clk), .rst_n(rst_n));

  tlb_top u_dut (.*);

  // Each VPN bit b lands on index bit (b mod 9) mod 6, on top of the low ASID bits
  function automatic logic [set_idx_w-1:0] model_set(input logic [asid_w-1:0] asid,
                                                     input logic [vpn_w-1:0] vpn);
    logic [set_idx_w-1:0] idx;
    idx = asid[set_idx_w-1:0];
    for (int b = 0; b < vpn_w; b++) begin
      idx[(b % vpn_field_w) % set_idx_w] ^= vpn[b];
    end
    return idx;
  endfunction

  // Expected answer with way 0 preferred on a double match
  function automatic exp_t ref_lookup(input logic [asid_w-1:0] asid,
                                      input logic [vpn_w-1:0] vpn);
    exp_t                 e;
    logic [set_idx_w-1:0] s;
    e = '0;
    s = model_set(asid, vpn);
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (m_valid[w][s] && (m_vpn[w][s] == vpn) &&
          (m_perm[w][s].g || (m_asid[w][s] == asid))) begin
        e.hit  = 1'b1;
        e.way  = w[0];
        e.ppn  = m_ppn[w][s];
        e.perm = m_perm[w][s];
      end
    end
    return e;
  endfunction

  // Used way saturates up and the other way saturates down
  task automatic bump(input logic [set_idx_w-1:0] s, input logic w);
    if (m_cnt[w][s] < cnt_max)
      m_cnt[w][s]++;
    if (m_cnt[!w][s] > 0)
      m_cnt[!w][s]--;
  endtask

  // --------------------------------------------------
  // Model update for the edge that closes this cycle
  // --------------------------------------------------
  task automatic model_step();
    exp_t                 e;
    logic [set_idx_w-1:0] hs, fs;
    logic                 fw;
    e  = '0;
    hs = model_set(pend_asid, pend_vpn);
    if (pend_valid) begin
      e = ref_lookup(pend_asid, pend_vpn);
      exp_q.push_back(e);
      exp_cyc_q.push_back(cyc + 1);
    end
    // Fill way comes from the state before any flush of this edge
    fs = model_set(refill_asid, refill_vpn);
    if (!m_valid[0][fs])
      fw = 1'b0;
    else if (!m_valid[1][fs])
      fw = 1'b1;
    else
      fw = (m_cnt[1][fs] < m_cnt[0][fs]);
    if (e.hit && !(refill_valid && (hs == fs)))
      bump(hs, e.way);
    if (refill_valid)
      bump(fs, fw);
    for (int w = 0; w < num_ways; w++) begin
      for (int s = 0; s < num_sets; s++) begin
        if (inv_all || (inv_asid_valid && !m_perm[w][s].g && (m_asid[w][s] == inv_asid)))
          m_valid[w][s] = 1'b0;
      end
    end
    if (refill_valid) begin
      m_valid[fw][fs] = 1'b1;
      m_asid[fw][fs]  = refill_asid;
      m_vpn[fw][fs]   = refill_vpn;
      m_ppn[fw][fs]   = refill_ppn;
      m_perm[fw][fs]  = refill_perm;
    end
    pend_valid = req_valid;
    pend_asid  = req_asid;
    pend_vpn   = req_vaddr[38:12];
  endtask

  task automatic next_cycle();
    model_step();
    @(posedge clk);
    #1;
    req_valid      = 1'b0;
    refill_valid   = 1'b0;
    inv_all        = 1'b0;
    inv_asid_valid = 1'b0;
  endtask

  // Upper address bits and page offset are random filler
  task automatic lookup(input logic [asid_w-1:0] asid, input logic [vpn_w-1:0] vpn);
    logic [31:0] r;
    r         = $random(seed);
    req_valid = 1'b1;
    req_asid  = asid;
    req_vaddr = {r[31:7], vpn, r[11:0]};
  endtask

  task automatic refill(input logic [asid_w-1:0] asid, input logic [vpn_w-1:0] vpn,
                        input logic [ppn_w-1:0] ppn, input tlb_perm_t perm);
    refill_valid = 1'b1;
    refill_asid  = asid;
    refill_vpn   = vpn;
    refill_ppn   = ppn;
    refill_perm  = perm;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Run stopped after a failure");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
      $display("Checks failed");
      $fatal(1, "Run stopped at the first mismatch");
    end
  endtask

  // --------------------------------------------------
  // Response compare and cycle limit
  // --------------------------------------------------
  always @(negedge clk) begin : compare_resp
    exp_t e;
    int   ec;
    if (rst_n) begin
      if ((exp_cyc_q.size() > 0) && (exp_cyc_q[0] < cyc)) begin
        abort_run("An expected lookup response never arrived");
      end else if (resp_valid) begin
        if (exp_q.size() == 0) begin
          abort_run("A response appeared with no lookup outstanding");
        end else begin
          e  = exp_q.pop_front();
          ec = exp_cyc_q.pop_front();
          check_value("response cycle", 64'(cyc), 64'(ec));
          check_value("resp_hit", {63'd0, resp_hit}, {63'd0, e.hit});
          check_value("resp_ppn", {20'd0, resp_ppn}, {20'd0, e.ppn});
          check_value("resp_perm", {57'd0, resp_perm}, {57'd0, e.perm});
        end
      end
    end
  end

  always @(posedge clk) begin
    if (cyc >= timeout_cycles)
      abort_run("Timeout, the run did not finish within the cycle limit");
    else
      cyc <= cyc + 1;
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin : stimulus
    logic [vpn_w-1:0]     v0, vn;
    logic [vpn_w-1:0]     coll [2];
    logic [set_idx_w-1:0] s0;
    logic [31:0]          r, r2;
    int                   n;
    seed           = 58;
    req_valid      = 1'b0;
    req_vaddr      = '0;
    req_asid       = '0;
    refill_valid   = 1'b0;
    refill_asid    = '0;
    refill_vpn     = '0;
    refill_ppn     = '0;
    refill_perm    = '0;
    inv_all        = 1'b0;
    inv_asid_valid = 1'b0;
    inv_asid       = '0;
    pend_valid     = 1'b0;
    pend_asid      = '0;
    pend_vpn       = '0;
    for (int w = 0; w < num_ways; w++) begin
      for (int s = 0; s < num_sets; s++) begin
        m_valid[w][s] = 1'b0;
        m_asid[w][s]  = '0;
        m_perm[w][s]  = '0;
        m_cnt[w][s]   = 0;
      end
    end
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;

    // Quiet pipeline, then cold misses
    repeat (4) next_cycle();
    lookup(16'd1, 27'h0000100);
    next_cycle();
    lookup(16'd2, 27'h7ffffff);
    next_cycle();
    lookup(16'd0, 27'h0000000);
    repeat (4) next_cycle();

    // Private and global entry, then back-to-back lookups
    refill(16'd5, 27'h0123456, 44'h0abcdef0123, tlb_perm_t'(7'b1100011));
    next_cycle();
    refill(16'd5, 27'h7654321, 44'h123456789ab, tlb_perm_t'(7'b1010111));
    next_cycle();
    lookup(16'd5, 27'h0123456);
    next_cycle();
    lookup(16'd9, 27'h0123456);
    next_cycle();
    lookup(16'd9, 27'h7654321);
    next_cycle();
    lookup(16'd5, 27'h7654321);
    repeat (4) next_cycle();

    // Three VPNs sharing one set
    v0 = 27'h0000100;
    s0 = set_hash(16'd3, v0);
    vn = v0;
    n  = 0;
    while (n < 2) begin
      vn = vn + 1'b1;
      if (set_hash(16'd3, vn) == s0) begin
        coll[n] = vn;
        n++;
      end
    end
    refill(16'd3, v0, {17'd0, v0}, tlb_perm_t'(7'b1100011));
    next_cycle();
    refill(16'd3, coll[0], {17'd0, coll[0]}, tlb_perm_t'(7'b1110011));
    next_cycle();
    refill(16'd3, coll[1], {17'd0, coll[1]}, tlb_perm_t'(7'b1001011));
    repeat (2) next_cycle();
    for (int i = 0; i < 6; i++) begin
      lookup(16'd3, (i == 0) ? v0 : (i == 1) ? coll[0] : coll[1]);
      next_cycle();
    end
    repeat (3) next_cycle();
    refill(16'd3, v0, {17'd1, v0}, tlb_perm_t'(7'b1100011));
    repeat (2) next_cycle();
    for (int i = 0; i < 3; i++) begin
      lookup(16'd3, (i == 0) ? v0 : (i == 1) ? coll[0] : coll[1]);
      next_cycle();
    end
    repeat (3) next_cycle();

    // Flush by ASID keeps globals and other ASIDs, flush all clears everything
    refill(16'd7, 27'h0055aa0, 44'h00000055aa0, tlb_perm_t'(7'b1101011));
    next_cycle();
    refill(16'd7, 27'h0055bb0, 44'h00000055bb0, tlb_perm_t'(7'b1100111));
    next_cycle();
    refill(16'd8, 27'h0055cc0, 44'h00000055cc0, tlb_perm_t'(7'b1101011));
    next_cycle();
    inv_asid_valid = 1'b1;
    inv_asid       = 16'd7;
    next_cycle();
    for (int i = 0; i < 2; i++) begin
      lookup(16'd7, 27'h0055aa0);
      inv_all = (i == 1);
      next_cycle();
      lookup(16'd2, 27'h0055bb0);
      next_cycle();
      lookup(16'd8, 27'h0055cc0);
      next_cycle();
    end
    repeat (3) next_cycle();

    // Random mix over a small VPN pool so hits and evictions are common
    repeat (random_cycles) begin
      r  = $random(seed);
      r2 = $random(seed);
      if (r[2:0] < 3'd5)
        lookup({14'd0, r[9:8]}, 27'h0200000 + {23'd0, r[13:10]});
      if (r[4:3] == 2'd0)
        refill({14'd0, r[15:14]}, 27'h0200000 + {23'd0, r[19:16]}, {r2, r[31:20]},
               tlb_perm_t'(r2[6:0]));
      inv_asid_valid = (r2[12:7] == 6'd0);
      inv_asid       = {14'd0, r2[14:13]};
      inv_all        = (r2[20:15] == 6'd0);
      next_cycle();
    end

    while (pend_valid || (exp_q.size() != 0))
      next_cycle();
    repeat (3) next_cycle();

    $display("All checks passed");
    $finish;
  end

endmodule

// File: build.f
logic/tlb_pkg.sv
logic/tlb_index_stage.sv
logic/tlb_way_array.sv
logic/tlb_replace.sv
logic/tlb_resp_stage.sv
logic/tlb_top.sv
tb/tb_clock.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the TLB testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_top -f build.f \
  --Mdir obj_dir -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
